// File: Bender.yml
package:
  name: rv_pipeline

sources:
  - hdl/rv_isa_pkg.sv
  - hdl/pipe_pkg.sv
  - hdl/fetch_unit.sv
  - hdl/reg_file.sv
  - hdl/decode_stage.sv
  - hdl/execute_unit.sv
  - hdl/retire_stage.sv
  - hdl/rv_pipeline_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/rv_pipeline_assertions.sv
      - testbench/rv_pipeline_tb.sv

// File: hdl/decode_stage.sv
module decode_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     flush_i,
  input  rv_isa_pkg::xlen_t        d_pc_i,
  input  rv_isa_pkg::rv_insn_u     d_insn_i,
  input  pipe_pkg::cycle_status_e  d_status_i,
  output rv_isa_pkg::reg_idx_t     rf_rs1_o,
  output rv_isa_pkg::reg_idx_t     rf_rs2_o,
  input  rv_isa_pkg::xlen_t        rf_rs1_data_i,
  input  rv_isa_pkg::xlen_t        rf_rs2_data_i,
  input  logic                     w_we_i,
  input  rv_isa_pkg::reg_idx_t     w_rd_i,
  input  rv_isa_pkg::xlen_t        w_data_i,
  output rv_isa_pkg::xlen_t        x_pc_o,
  output rv_isa_pkg::rv_insn_u     x_insn_o,
  output pipe_pkg::cycle_status_e  x_status_o,
  output rv_isa_pkg::alu_op_e      x_op_o,
  output rv_isa_pkg::reg_idx_t     x_rd_o,
  output rv_isa_pkg::reg_idx_t     x_rs1_o,
  output rv_isa_pkg::reg_idx_t     x_rs2_o,
  output rv_isa_pkg::xlen_t        x_rs1_data_o,
  output rv_isa_pkg::xlen_t        x_rs2_data_o,
  output rv_isa_pkg::xlen_t        x_imm_o
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  xlen_t   imm_i;
  xlen_t   imm_b;
  xlen_t   imm_u;
  xlen_t   d_imm;
  alu_op_e d_op;
  xlen_t   rs1_val;
  xlen_t   rs2_val;

  // operation selected by funct3 when funct7 is zero
  function automatic alu_op_e base_op(logic [2:0] f3);
    case (f3)
      F3_ADD:  return ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SR:   return ALU_SRL;
      F3_OR:   return ALU_OR;
      F3_AND:  return ALU_AND;
      default: return ALU_NOP;
    endcase
  endfunction

  assign imm_i = {{20{d_insn_i.i.imm[11]}}, d_insn_i.i.imm};
  assign imm_b = {{19{d_insn_i.sb.hi[6]}}, d_insn_i.sb.hi[6], d_insn_i.sb.lo[0],
                  d_insn_i.sb.hi[5:0], d_insn_i.sb.lo[4:1], 1'b0};
  assign imm_u = {d_insn_i.u.imm, 12'b0};

  always_comb begin
    d_op  = ALU_NOP;
    d_imm = '0;
    case (d_insn_i.r.opcode)
      OP_LUI: begin
        d_op  = ALU_LUI;
        d_imm = imm_u;
      end
      OP_AUIPC: begin
        d_op  = ALU_AUIPC;
        d_imm = imm_u;
      end
      OP_REG_IMM: begin
        d_imm = imm_i;
        // shifts keep funct7 in the upper immediate bits
        if (d_insn_i.r.funct3 == F3_SLL || d_insn_i.r.funct3 == F3_SR) begin
          if (d_insn_i.r.funct7 == '0) begin
            d_op = base_op(d_insn_i.r.funct3);
          end else if (d_insn_i.r.funct7 == F7_ALT && d_insn_i.r.funct3 == F3_SR) begin
            d_op = ALU_SRA;
          end
        end else begin
          d_op = base_op(d_insn_i.r.funct3);
        end
      end
      OP_REG_REG: begin
        if (d_insn_i.r.funct7 == '0) begin
          d_op = base_op(d_insn_i.r.funct3);
        end else if (d_insn_i.r.funct7 == F7_ALT && d_insn_i.r.funct3 == F3_ADD) begin
          d_op = ALU_SUB;
        end else if (d_insn_i.r.funct7 == F7_ALT && d_insn_i.r.funct3 == F3_SR) begin
          d_op = ALU_SRA;
        end
      end
      OP_BRANCH: begin
        d_imm = imm_b;
        case (d_insn_i.sb.funct3)
          F3_BEQ:  d_op = BR_EQ;
          F3_BNE:  d_op = BR_NE;
          F3_BLT:  d_op = BR_LT;
          F3_BGE:  d_op = BR_GE;
          F3_BLTU: d_op = BR_LTU;
          F3_BGEU: d_op = BR_GEU;
          default: d_op = ALU_NOP;
        endcase
      end
      OP_ENVIRON: begin
        // only ecall, every field above the opcode zero
        if (d_insn_i[31:7] == '0) begin
          d_op = ALU_HALT;
        end
      end
      OP_MISC_MEM: d_op = ALU_NOP;
      default:     d_op = ALU_NOP;
    endcase
  end

  assign rf_rs1_o = d_insn_i.r.rs1;
  assign rf_rs2_o = d_insn_i.r.rs2;

  // writeback lands in the file only at the edge, so pass it through now
  assign rs1_val = (w_we_i && w_rd_i == rf_rs1_o) ? w_data_i : rf_rs1_data_i;
  assign rs2_val = (w_we_i && w_rd_i == rf_rs2_o) ? w_data_i : rf_rs2_data_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      x_pc_o     <= '0;
      x_insn_o   <= '0;
      x_status_o <= CYCLE_RESET;
      x_op_o     <= ALU_NOP;
      x_rd_o     <= '0;
    end else if (flush_i) begin
      x_pc_o     <= '0;
      x_insn_o   <= '0;
      x_status_o <= CYCLE_TAKEN_BRANCH;
      x_op_o     <= ALU_NOP;
      x_rd_o     <= '0;
    end else begin
      x_pc_o     <= d_pc_i;
      x_insn_o   <= d_insn_i;
      x_status_o <= d_status_i;
      x_op_o     <= d_op;
      x_rd_o     <= d_insn_i.r.rd;
    end
  end

  // operands and indices, meaningless once the op is a nop
  always_ff @(posedge clk) begin
    x_rs1_o      <= rf_rs1_o;
    x_rs2_o      <= rf_rs2_o;
    x_rs1_data_o <= rs1_val;
    x_rs2_data_o <= rs2_val;
    x_imm_o      <= d_imm;
  end

endmodule

// File: hdl/execute_unit.sv
module execute_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  rv_isa_pkg::xlen_t        x_pc_i,
  input  rv_isa_pkg::rv_insn_u     x_insn_i,
  input  pipe_pkg::cycle_status_e  x_status_i,
  input  rv_isa_pkg::alu_op_e      x_op_i,
  input  rv_isa_pkg::reg_idx_t     x_rd_i,
  input  rv_isa_pkg::reg_idx_t     x_rs1_i,
  input  rv_isa_pkg::reg_idx_t     x_rs2_i,
  input  rv_isa_pkg::xlen_t        x_rs1_data_i,
  input  rv_isa_pkg::xlen_t        x_rs2_data_i,
  input  rv_isa_pkg::xlen_t        x_imm_i,
  input  logic                     m_we_i,
  input  rv_isa_pkg::reg_idx_t     m_rd_i,
  input  rv_isa_pkg::xlen_t        m_data_i,
  input  logic                     w_we_i,
  input  rv_isa_pkg::reg_idx_t     w_rd_i,
  input  rv_isa_pkg::xlen_t        w_data_i,
  output logic                     branch_taken_o,
  output rv_isa_pkg::xlen_t        branch_target_o,
  output rv_isa_pkg::xlen_t        m_pc_o,
  output rv_isa_pkg::rv_insn_u     m_insn_o,
  output pipe_pkg::cycle_status_e  m_status_o,
  output logic                     m_we_o,
  output rv_isa_pkg::reg_idx_t     m_rd_o,
  output rv_isa_pkg::xlen_t        m_data_o,
  output logic                     m_halt_o
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  xlen_t rs1_val;
  xlen_t rs2_val;
  xlen_t op_b;
  xlen_t target;
  xlen_t alu_res;
  logic  use_imm;
  logic  writes;
  logic  taken;

  // youngest producer wins: memory, then writeback, then stage register
  assign rs1_val = (m_we_i && m_rd_i == x_rs1_i) ? m_data_i :
                   (w_we_i && w_rd_i == x_rs1_i) ? w_data_i : x_rs1_data_i;
  assign rs2_val = (m_we_i && m_rd_i == x_rs2_i) ? m_data_i :
                   (w_we_i && w_rd_i == x_rs2_i) ? w_data_i : x_rs2_data_i;

  assign use_imm = (x_insn_i.r.opcode == OP_REG_IMM);
  assign op_b    = use_imm ? x_imm_i : rs2_val;

  // shared by branch target and auipc
  assign target = x_pc_i + x_imm_i;

  always_comb begin
    case (x_op_i)
      ALU_ADD:   alu_res = rs1_val + op_b;
      ALU_SUB:   alu_res = rs1_val - op_b;
      ALU_SLL:   alu_res = rs1_val << op_b[4:0];
      ALU_SLT:   alu_res = xlen_t'($signed(rs1_val) < $signed(op_b));
      ALU_SLTU:  alu_res = xlen_t'(rs1_val < op_b);
      ALU_XOR:   alu_res = rs1_val ^ op_b;
      ALU_SRL:   alu_res = rs1_val >> op_b[4:0];
      ALU_SRA:   alu_res = $signed(rs1_val) >>> op_b[4:0];
      ALU_OR:    alu_res = rs1_val | op_b;
      ALU_AND:   alu_res = rs1_val & op_b;
      ALU_LUI:   alu_res = x_imm_i;
      ALU_AUIPC: alu_res = target;
      default:   alu_res = '0;
    endcase
  end

  always_comb begin
    case (x_op_i)
      BR_EQ:   taken = (rs1_val == op_b);
      BR_NE:   taken = (rs1_val != op_b);
      BR_LT:   taken = ($signed(rs1_val) < $signed(op_b));
      BR_GE:   taken = ($signed(rs1_val) >= $signed(op_b));
      BR_LTU:  taken = (rs1_val < op_b);
      BR_GEU:  taken = (rs1_val >= op_b);
      default: taken = 1'b0;
    endcase
  end

  assign writes = x_op_i inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
                                 ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC};

  assign branch_taken_o  = taken;
  assign branch_target_o = target;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc_o     <= '0;
      m_insn_o   <= '0;
      m_status_o <= CYCLE_RESET;
      m_we_o     <= 1'b0;
      m_rd_o     <= '0;
      m_halt_o   <= 1'b0;
    end else begin
      m_pc_o     <= x_pc_i;
      m_insn_o   <= x_insn_i;
      m_status_o <= x_status_i;
      // x0 writes dropped here so bypass compares need no zero check
      m_we_o     <= writes && (x_rd_i != '0);
      m_rd_o     <= x_rd_i;
      m_halt_o   <= (x_op_i == ALU_HALT);
    end
  end

  always_ff @(posedge clk) begin
    m_data_o <= alu_res;
  end

endmodule

// File: hdl/fetch_unit.sv
module fetch_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     branch_taken_i,
  input  rv_isa_pkg::xlen_t        branch_target_i,
  output rv_isa_pkg::xlen_t        pc_o,
  input  rv_isa_pkg::rv_insn_u     insn_i,
  output rv_isa_pkg::xlen_t        d_pc_o,
  output rv_isa_pkg::rv_insn_u     d_insn_o,
  output pipe_pkg::cycle_status_e  d_status_o
);
  import pipe_pkg::*;

  // program counter
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_o <= RESET_PC;
    end else if (branch_taken_i) begin
      pc_o <= branch_target_i;
    end else begin
      pc_o <= pc_o + PC_STEP;
    end
  end

  // word arrives in the same cycle as the pc, straight into decode
  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc_o     <= '0;
      d_insn_o   <= '0;
      d_status_o <= CYCLE_RESET;
    end else if (branch_taken_i) begin
      // wrong-path fetch becomes a bubble
      d_pc_o     <= '0;
      d_insn_o   <= '0;
      d_status_o <= CYCLE_TAKEN_BRANCH;
    end else begin
      d_pc_o     <= pc_o;
      d_insn_o   <= insn_i;
      d_status_o <= CYCLE_NO_STALL;
    end
  end

endmodule

// File: hdl/pipe_pkg.sv
package pipe_pkg;

  // status carried with each slot down to the trace
  typedef enum logic [1:0] {
    CYCLE_RESET        = 2'd0,
    CYCLE_NO_STALL     = 2'd1,
    CYCLE_TAKEN_BRANCH = 2'd2
  } cycle_status_e;

  localparam rv_isa_pkg::xlen_t RESET_PC = 32'h0000_0000;
  localparam rv_isa_pkg::xlen_t PC_STEP  = 32'd4;

endpackage

// File: hdl/reg_file.sv
module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  we_i,
  input  rv_isa_pkg::reg_idx_t  rd_i,
  input  rv_isa_pkg::xlen_t     rd_data_i,
  input  rv_isa_pkg::reg_idx_t  rs1_i,
  input  rv_isa_pkg::reg_idx_t  rs2_i,
  output rv_isa_pkg::xlen_t     rs1_data_o,
  output rv_isa_pkg::xlen_t     rs2_data_o
);
  import rv_isa_pkg::*;

  xlen_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (we_i && rd_i != '0) begin
      regs[rd_i] <= rd_data_i;
    end
  end

  // x0 reads as zero
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// File: hdl/retire_stage.sv
module retire_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  rv_isa_pkg::xlen_t        m_pc_i,
  input  rv_isa_pkg::rv_insn_u     m_insn_i,
  input  pipe_pkg::cycle_status_e  m_status_i,
  input  logic                     m_we_i,
  input  rv_isa_pkg::reg_idx_t     m_rd_i,
  input  rv_isa_pkg::xlen_t        m_data_i,
  input  logic                     m_halt_i,
  output logic                     w_we_o,
  output rv_isa_pkg::reg_idx_t     w_rd_o,
  output rv_isa_pkg::xlen_t        w_data_o,
  output rv_isa_pkg::xlen_t        wb_pc_o,
  output rv_isa_pkg::rv_insn_u     wb_insn_o,
  output pipe_pkg::cycle_status_e  wb_status_o,
  output logic                     halt_o
);
  import pipe_pkg::*;

  always_ff @(posedge clk) begin
    if (rst) begin
      w_we_o      <= 1'b0;
      w_rd_o      <= '0;
      wb_pc_o     <= '0;
      wb_insn_o   <= '0;
      wb_status_o <= CYCLE_RESET;
      halt_o      <= 1'b0;
    end else begin
      w_we_o      <= m_we_i;
      w_rd_o      <= m_rd_i;
      wb_pc_o     <= m_pc_i;
      wb_insn_o   <= m_insn_i;
      wb_status_o <= m_status_i;
      // sticky once the ecall reaches writeback
      halt_o      <= halt_o | m_halt_i;
    end
  end

  always_ff @(posedge clk) begin
    w_data_o <= m_data_i;
  end

endmodule

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int XLEN = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [6:0] opcode_t;

  // major opcodes, low two bits always 2'b11
  localparam opcode_t OP_LUI      = 7'b0110111;
  localparam opcode_t OP_AUIPC    = 7'b0010111;
  localparam opcode_t OP_BRANCH   = 7'b1100011;
  localparam opcode_t OP_REG_IMM  = 7'b0010011;
  localparam opcode_t OP_REG_REG  = 7'b0110011;
  localparam opcode_t OP_ENVIRON  = 7'b1110011;
  localparam opcode_t OP_MISC_MEM = 7'b0001111;

  // funct7 for sub / sra / srai
  localparam logic [6:0] F7_ALT = 7'b0100000;

  // alu funct3
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_t    opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_t     opcode;
  } i_view_t;

  // store and branch share the split immediate layout
  typedef struct packed {
    logic [6:0] hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] lo;
    opcode_t    opcode;
  } sb_view_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    opcode_t     opcode;
  } u_view_t;

  typedef union packed {
    r_view_t  r;
    i_view_t  i;
    sb_view_t sb;
    u_view_t  u;
  } rv_insn_u;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_LUI, ALU_AUIPC,
    BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU,
    ALU_HALT, ALU_NOP
  } alu_op_e;

endpackage

// File: hdl/rv_pipeline_top.sv
module rv_pipeline_top (
  input  logic                     clk,
  input  logic                     rst,
  output rv_isa_pkg::xlen_t        pc_o,
  input  rv_isa_pkg::rv_insn_u     insn_i,
  output rv_isa_pkg::xlen_t        wb_pc_o,
  output rv_isa_pkg::rv_insn_u     wb_insn_o,
  output pipe_pkg::cycle_status_e  wb_status_o,
  output logic                     wb_we_o,
  output rv_isa_pkg::reg_idx_t     wb_rd_o,
  output rv_isa_pkg::xlen_t        wb_data_o,
  output logic                     halt_o
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  // fetch to decode
  xlen_t         d_pc;
  rv_insn_u      d_insn;
  cycle_status_e d_status;

  // register file read side
  reg_idx_t rf_rs1;
  reg_idx_t rf_rs2;
  xlen_t    rf_rs1_data;
  xlen_t    rf_rs2_data;

  // decode to execute
  xlen_t         x_pc;
  rv_insn_u      x_insn;
  cycle_status_e x_status;
  alu_op_e       x_op;
  reg_idx_t      x_rd;
  reg_idx_t      x_rs1;
  reg_idx_t      x_rs2;
  xlen_t         x_rs1_data;
  xlen_t         x_rs2_data;
  xlen_t         x_imm;

  logic  branch_taken;
  xlen_t branch_target;

  // execute to retire
  xlen_t         m_pc;
  rv_insn_u      m_insn;
  cycle_status_e m_status;
  logic          m_we;
  reg_idx_t      m_rd;
  xlen_t         m_data;
  logic          m_halt;

  fetch_unit fetch_unit_inst (
    .clk             (clk),
    .rst             (rst),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .pc_o            (pc_o),
    .insn_i          (insn_i),
    .d_pc_o          (d_pc),
    .d_insn_o        (d_insn),
    .d_status_o      (d_status)
  );

  // write port fed from the writeback outputs
  reg_file reg_file_inst (
    .clk        (clk),
    .rst        (rst),
    .we_i       (wb_we_o),
    .rd_i       (wb_rd_o),
    .rd_data_i  (wb_data_o),
    .rs1_i      (rf_rs1),
    .rs2_i      (rf_rs2),
    .rs1_data_o (rf_rs1_data),
    .rs2_data_o (rf_rs2_data)
  );

  decode_stage decode_stage_inst (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (branch_taken),
    .d_pc_i        (d_pc),
    .d_insn_i      (d_insn),
    .d_status_i    (d_status),
    .rf_rs1_o      (rf_rs1),
    .rf_rs2_o      (rf_rs2),
    .rf_rs1_data_i (rf_rs1_data),
    .rf_rs2_data_i (rf_rs2_data),
    .w_we_i        (wb_we_o),
    .w_rd_i        (wb_rd_o),
    .w_data_i      (wb_data_o),
    .x_pc_o        (x_pc),
    .x_insn_o      (x_insn),
    .x_status_o    (x_status),
    .x_op_o        (x_op),
    .x_rd_o        (x_rd),
    .x_rs1_o       (x_rs1),
    .x_rs2_o       (x_rs2),
    .x_rs1_data_o  (x_rs1_data),
    .x_rs2_data_o  (x_rs2_data),
    .x_imm_o       (x_imm)
  );

  execute_unit execute_unit_inst (
    .clk             (clk),
    .rst             (rst),
    .x_pc_i          (x_pc),
    .x_insn_i        (x_insn),
    .x_status_i      (x_status),
    .x_op_i          (x_op),
    .x_rd_i          (x_rd),
    .x_rs1_i         (x_rs1),
    .x_rs2_i         (x_rs2),
    .x_rs1_data_i    (x_rs1_data),
    .x_rs2_data_i    (x_rs2_data),
    .x_imm_i         (x_imm),
    .m_we_i          (m_we),
    .m_rd_i          (m_rd),
    .m_data_i        (m_data),
    .w_we_i          (wb_we_o),
    .w_rd_i          (wb_rd_o),
    .w_data_i        (wb_data_o),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target),
    .m_pc_o          (m_pc),
    .m_insn_o        (m_insn),
    .m_status_o      (m_status),
    .m_we_o          (m_we),
    .m_rd_o          (m_rd),
    .m_data_o        (m_data),
    .m_halt_o        (m_halt)
  );

  retire_stage retire_stage_inst (
    .clk         (clk),
    .rst         (rst),
    .m_pc_i      (m_pc),
    .m_insn_i    (m_insn),
    .m_status_i  (m_status),
    .m_we_i      (m_we),
    .m_rd_i      (m_rd),
    .m_data_i    (m_data),
    .m_halt_i    (m_halt),
    .w_we_o      (wb_we_o),
    .w_rd_o      (wb_rd_o),
    .w_data_o    (wb_data_o),
    .wb_pc_o     (wb_pc_o),
    .wb_insn_o   (wb_insn_o),
    .wb_status_o (wb_status_o),
    .halt_o      (halt_o)
  );

endmodule

// File: src.f
hdl/rv_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_unit.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_unit.sv
hdl/retire_stage.sv
hdl/rv_pipeline_top.sv
testbench/tb_clock_gen.sv
testbench/rv_pipeline_assertions.sv
testbench/rv_pipeline_tb.sv

// File: testbench/rv_pipeline_assertions.sv
module rv_pipeline_assertions (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     wb_we_i,
  input  rv_isa_pkg::reg_idx_t     wb_rd_i,
  input  pipe_pkg::cycle_status_e  wb_status_i,
  input  logic                     halt_i
);
  import pipe_pkg::*;

  // polled by the testbench every cycle
  int failures = 0;

  we_needs_rd: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_we_i |-> wb_rd_i != '0)
    else begin
      failures++;
      $error("writeback enable with rd of zero");
    end

  // bubbles and reset slots never write
  bubble_no_write: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_status_i != CYCLE_NO_STALL |-> !wb_we_i)
    else begin
      failures++;
      $error("write enable high on a slot that is not NO_STALL");
    end

  halt_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    halt_i |=> halt_i)
    else begin
      failures++;
      $error("halt dropped without a reset");
    end

endmodule

// File: testbench/rv_pipeline_tb.sv
module rv_pipeline_tb;
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  localparam int PROG_WORDS   = 256;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_CYCLES   = RESET_CYCLES + 3 * PROG_WORDS + 64;
  localparam xlen_t ECALL_WORD = 32'h0000_0073;

  typedef struct {
    xlen_t    pc;
    rv_insn_u insn;
    logic     we;
    reg_idx_t rd;
    xlen_t    data;
    logic     taken;
  } retire_t;

  logic          clk;
  logic          rst;
  xlen_t         pc;
  rv_insn_u      insn;
  xlen_t         wb_pc;
  rv_insn_u      wb_insn;
  cycle_status_e wb_status;
  logic          wb_we;
  reg_idx_t      wb_rd;
  xlen_t         wb_data;
  logic          halt;

  rv_insn_u imem [PROG_WORDS];
  retire_t  expected [$];
  int       next_rec = 0;
  int       bubbles = 0;
  logic     seen_first = 1'b0;
  logic     done;
  int       cycle_count = 0;

  tb_clock_gen clock_inst (
    .clk_o (clk)
  );

  rv_pipeline_top rv_pipeline_top_inst (
    .clk         (clk),
    .rst         (rst),
    .pc_o        (pc),
    .insn_i      (insn),
    .wb_pc_o     (wb_pc),
    .wb_insn_o   (wb_insn),
    .wb_status_o (wb_status),
    .wb_we_o     (wb_we),
    .wb_rd_o     (wb_rd),
    .wb_data_o   (wb_data),
    .halt_o      (halt)
  );

  bind rv_pipeline_top rv_pipeline_assertions assertions_inst (
    .clk_i       (clk),
    .rst_i       (rst),
    .wb_we_i     (wb_we_o),
    .wb_rd_i     (wb_rd_o),
    .wb_status_i (wb_status_o),
    .halt_i      (halt_o)
  );

  // anything past the program reads as ecall
  function automatic rv_insn_u fetch_word(xlen_t addr);
    if (addr < PROG_WORDS * 4) begin
      return imem[addr[9:2]];
    end
    return ECALL_WORD;
  endfunction

  always_comb begin
    insn = fetch_word(pc);
  end

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string what, input xlen_t exp, input xlen_t got);
    if (got !== exp) begin
      $display("Fail at %0t: %s expected %h, got %h", $time, what, exp, got);
      abort_run();
    end
  endtask

  task automatic check_insn(input string what, input rv_insn_u exp, input rv_insn_u got);
    if (got !== exp) begin
      $display("Fail at %0t: %s expected %h, got %h", $time, what, exp, got);
      abort_run();
    end
  endtask

  task automatic check_reg(input string what, input reg_idx_t exp, input reg_idx_t got);
    if (got !== exp) begin
      $display("Fail at %0t: %s expected x%0d, got x%0d", $time, what, exp, got);
      abort_run();
    end
  endtask

  task automatic check_status(input string what, input cycle_status_e exp,
                              input cycle_status_e got);
    if (got !== exp) begin
      $display("Fail at %0t: %s expected %s, got %s", $time, what, exp.name(), got.name());
      abort_run();
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic got);
    if (got !== exp) begin
      $display("Fail at %0t: %s expected %b, got %b", $time, what, exp, got);
      abort_run();
    end
  endtask

  task automatic poll_assertions();
    if (rv_pipeline_top_inst.assertions_inst.failures != 0) begin
      $display("An assertion on the writeback outputs failed");
      abort_run();
    end
  endtask

  // registers mostly x0..x4 so producers and consumers sit close together
  function automatic reg_idx_t pick_reg();
    if ($urandom % 4 != 0) begin
      return reg_idx_t'($urandom % 5);
    end
    return reg_idx_t'($urandom % 32);
  endfunction

  task automatic generate_program();
    int          kind;
    int          off;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm12;
    logic [12:0] bimm;
    for (int i = 0; i < PROG_WORDS - 1; i++) begin
      kind = $urandom % 16;
      rd   = pick_reg();
      rs1  = pick_reg();
      rs2  = pick_reg();
      f3   = 3'($urandom);
      if (kind < 1) begin
        imem[i] = {20'($urandom), rd, OP_LUI};
      end else if (kind < 2) begin
        imem[i] = {20'($urandom), rd, OP_AUIPC};
      end else if (kind < 7) begin
        imm12 = 12'($urandom);
        if (f3 == F3_SLL) begin
          imm12 = {7'b0, imm12[4:0]};
        end else if (f3 == F3_SR) begin
          imm12 = {($urandom % 2) ? F7_ALT : 7'b0, imm12[4:0]};
        end
        imem[i] = {imm12, rs1, f3, rd, OP_REG_IMM};
      end else if (kind < 12) begin
        f7 = ((f3 == F3_ADD || f3 == F3_SR) && $urandom % 2) ? F7_ALT : 7'b0;
        imem[i] = {f7, rs2, rs1, f3, rd, OP_REG_REG};
      end else if (kind < 14) begin
        // forward only, 8 to 32 bytes, target inside the program
        off = 4 * (2 + $urandom % 7);
        if (i + off / 4 < PROG_WORDS) begin
          f3 = 3'($urandom % 6);
          if (f3 >= 2) begin
            f3 = f3 + 3'd2;
          end
          bimm = 13'(off);
          imem[i] = {bimm[12], bimm[10:5], rs2, rs1, f3, bimm[4:1], bimm[11], OP_BRANCH};
        end else begin
          imem[i] = {7'b0, rs2, rs1, F3_ADD, rd, OP_REG_REG};
        end
      end else if (kind < 15) begin
        imem[i] = {4'b0, 4'($urandom), 4'($urandom), 5'b0, 3'b0, 5'b0, OP_MISC_MEM};
      end else begin
        // load or jal encodings, outside the supported set
        imem[i] = {25'($urandom), ($urandom % 2) ? 7'b0000011 : 7'b1101111};
      end
    end
    imem[PROG_WORDS-1] = ECALL_WORD;
  endtask

  function automatic xlen_t reference_alu(logic [2:0] f3, logic alt, logic is_reg,
                                          xlen_t a, xlen_t b);
    case (f3)
      3'd0:    return (alt && is_reg) ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_outcome(logic [2:0] f3, xlen_t a, xlen_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // in-order execution, one record per retired instruction
  task automatic run_model();
    xlen_t    regs [NUM_REGS];
    xlen_t    mpc;
    xlen_t    a;
    xlen_t    b;
    xlen_t    imm;
    rv_insn_u w;
    retire_t  r;
    logic     halted;
    mpc = RESET_PC;
    halted = 1'b0;
    imm = '0;
    foreach (regs[k]) begin
      regs[k] = '0;
    end
    while (!halted) begin
      w = fetch_word(mpc);
      a = regs[w.r.rs1];
      b = regs[w.r.rs2];
      r.pc = mpc;
      r.insn = w;
      r.rd = w.r.rd;
      r.data = '0;
      r.we = 1'b0;
      r.taken = 1'b0;
      case (w.r.opcode)
        OP_LUI: begin
          r.data = {w.u.imm, 12'b0};
          r.we = 1'b1;
        end
        OP_AUIPC: begin
          r.data = mpc + {w.u.imm, 12'b0};
          r.we = 1'b1;
        end
        OP_REG_IMM: begin
          imm = {{20{w.i.imm[11]}}, w.i.imm};
          r.data = reference_alu(w.r.funct3, w.r.funct7[5], 1'b0, a, imm);
          r.we = 1'b1;
        end
        OP_REG_REG: begin
          r.data = reference_alu(w.r.funct3, w.r.funct7[5], 1'b1, a, b);
          r.we = 1'b1;
        end
        OP_BRANCH: begin
          imm = {{20{w.sb.hi[6]}}, w.sb.lo[0], w.sb.hi[5:0], w.sb.lo[4:1], 1'b0};
          r.taken = branch_outcome(w.sb.funct3, a, b);
        end
        OP_ENVIRON: halted = (w == ECALL_WORD);
        default: r.we = 1'b0;
      endcase
      r.we = r.we && (r.rd != '0);
      if (r.we) begin
        regs[r.rd] = r.data;
      end
      expected.push_back(r);
      mpc = r.taken ? mpc + imm : mpc + PC_STEP;
    end
  endtask

  task automatic check_slot();
    retire_t r;
    case (wb_status)
      CYCLE_RESET: begin
        if (seen_first) begin
          $display("Reset status reached writeback after the program had started");
          abort_run();
        end else begin
          check_flag("write enable in reset slot", 1'b0, wb_we);
        end
      end
      CYCLE_TAKEN_BRANCH: begin
        if (bubbles == 0) begin
          $display("Branch bubble at writeback with no taken branch before it");
          abort_run();
        end else begin
          check_flag("write enable in branch bubble", 1'b0, wb_we);
          bubbles--;
        end
      end
      CYCLE_NO_STALL: begin
        if (bubbles != 0) begin
          $display("Instruction retired before both bubbles of a taken branch");
          abort_run();
        end else if (next_rec >= expected.size()) begin
          $display("Instruction retired after the expected program had ended");
          abort_run();
        end else begin
          r = expected[next_rec];
          check_word("retired pc", r.pc, wb_pc);
          check_insn("retired instruction", r.insn, wb_insn);
          check_flag("write enable", r.we, wb_we);
          if (r.we) begin
            check_reg("destination register", r.rd, wb_rd);
            check_word("written data", r.data, wb_data);
          end
          if (r.taken) begin
            bubbles = 2;
          end
          next_rec++;
          seen_first = 1'b1;
        end
      end
      default: begin
        $display("Writeback status holds an undefined value");
        abort_run();
      end
    endcase
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: halt not seen within %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  initial begin
    void'($urandom(75));
    rst = 1'b1;
    generate_program();
    run_model();
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_status("status during reset", CYCLE_RESET, wb_status);
    check_flag("write enable during reset", 1'b0, wb_we);
    check_flag("halt during reset", 1'b0, halt);
    check_word("fetch pc during reset", RESET_PC, pc);
    @(posedge clk);
    rst <= 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      check_slot();
      poll_assertions();
      done = halt;
    end
    // one more edge so the held halt is sampled
    @(negedge clk);
    check_flag("halt one cycle after the ecall", 1'b1, halt);
    poll_assertions();
    if (next_rec != expected.size()) begin
      $display("Halt rose before every expected instruction had retired");
      abort_run();
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk_o
);

  // period of 4
  initial begin
    clk_o = 1'b0;
  end

  always begin
    #2 clk_o = ~clk_o;
  end

endmodule
